// File: design/sq_cfg.svh
`ifndef SQ_CFG_SVH
`define SQ_CFG_SVH

// Limb geometry of a residue
`define SQ_WORD_LEN   16
`define SQ_NUM_LIMBS  4
`define SQ_VALUE_LEN  64

// P = 2^64 - SQ_FOLD_C
`define SQ_FOLD_C     59

// Width of the requested squaring count
`define SQ_COUNT_LEN  16

`endif

// File: design/sq_pkg.sv
`default_nettype none

`include "sq_cfg.svh"

package sq_pkg;

    // One 16-bit limb
    typedef logic [`SQ_WORD_LEN-1:0] word_t;

    // Residue, four limbs
    typedef logic [`SQ_VALUE_LEN-1:0] value_t;

    // Full square before reduction
    typedef logic [2*`SQ_VALUE_LEN-1:0] square_t;

    // Column sum: product, doubling bit and two bits of growth
    typedef logic [2*`SQ_WORD_LEN+2:0] column_t;

    typedef logic [`SQ_COUNT_LEN-1:0] count_t;

    typedef enum logic [1:0] {
        IDLE,
        SQUARE,
        FOLD,
        FINISH
    } state_e;

endpackage

`default_nettype wire

// File: design/sq_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "sq_cfg.svh"

module sq_ctrl
    import sq_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   start,
    input  wire count_t iterations,
    output logic        load,
    output logic        fold,
    output logic        finish,
    output logic        busy
);

    state_e state;
    state_e state_next;

    count_t count;
    count_t count_dec;

    logic   iterations_zero;
    logic   last_fold;

    assign count_dec = count - count_t'(1);

    assign iterations_zero = (iterations == {`SQ_COUNT_LEN{1'b0}});
    assign last_fold       = (count_dec == {`SQ_COUNT_LEN{1'b0}});

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                // Zero iterations skips straight to the correction
                if (start) begin
                    state_next = iterations_zero ? FINISH : SQUARE;
                end
            end
            SQUARE: begin
                state_next = FOLD;
            end
            FOLD: begin
                state_next = last_fold ? FINISH : SQUARE;
            end
            FINISH: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Loop counter, counts remaining squarings down
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= iterations;
        end else if (fold) begin
            count <= count_dec;
        end
    end

    // Start is only accepted from IDLE
    assign load   = (state == IDLE) && (state_next != IDLE);
    assign fold   = (state == FOLD);
    assign finish = (state == FINISH);
    assign busy   = (state != IDLE);

endmodule

`default_nettype wire

// File: design/sq_limb_square.sv
`timescale 1ns/1ps
`default_nettype none

`include "sq_cfg.svh"

module sq_limb_square
    import sq_pkg::*;
(
    input  wire logic   clk,
    input  wire value_t value,
    output square_t     square
);

    localparam int NUM_COLUMNS = 2*`SQ_NUM_LIMBS - 1;

    word_t   limb [`SQ_NUM_LIMBS];
    column_t column [NUM_COLUMNS];
    square_t square_comb;

    always_comb begin
        for (int i = 0; i < `SQ_NUM_LIMBS; i++) begin
            limb[i] = value[i*`SQ_WORD_LEN +: `SQ_WORD_LEN];
        end
    end

    // Column grid, each off-diagonal pair appears once and is doubled
    always_comb begin
        logic [2*`SQ_WORD_LEN-1:0] product;
        product = '0;
        for (int k = 0; k < NUM_COLUMNS; k++) begin
            column[k] = '0;
            for (int i = 0; i < `SQ_NUM_LIMBS; i++) begin
                for (int j = i; j < `SQ_NUM_LIMBS; j++) begin
                    if (i + j == k) begin
                        product = limb[i] * limb[j];
                        if (i == j) begin
                            column[k] = column[k] + column_t'(product);
                        end else begin
                            column[k] = column[k] + (column_t'(product) << 1);
                        end
                    end
                end
            end
        end
    end

    // Ripple the column carries up into 16-bit result limbs
    always_comb begin
        column_t acc;
        acc = '0;
        for (int k = 0; k < NUM_COLUMNS; k++) begin
            acc = column[k] + (acc >> `SQ_WORD_LEN);
            square_comb[k*`SQ_WORD_LEN +: `SQ_WORD_LEN] = acc[`SQ_WORD_LEN-1:0];
        end
        // Last carry is the top limb, always below 2^16
        square_comb[NUM_COLUMNS*`SQ_WORD_LEN +: `SQ_WORD_LEN] =
            acc[2*`SQ_WORD_LEN-1:`SQ_WORD_LEN];
    end

    always_ff @(posedge clk) begin
        square <= square_comb;
    end

endmodule

`default_nettype wire

// File: design/sq_fold_reduce.sv
`timescale 1ns/1ps
`default_nettype none

`include "sq_cfg.svh"

module sq_fold_reduce
    import sq_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    load,
    input  wire logic    fold,
    input  wire value_t  sq_in,
    input  wire square_t square,
    output value_t       value
);

    localparam int FOLD_W     = $clog2(`SQ_FOLD_C + 1);
    localparam int STAGE1_LEN = `SQ_VALUE_LEN + FOLD_W + 1;
    localparam int STAGE2_LEN = `SQ_VALUE_LEN + 1;

    logic [STAGE1_LEN-1:0] stage1;
    logic [STAGE2_LEN-1:0] stage2;
    value_t                folded;

    // 2^64 is congruent to SQ_FOLD_C, so high * C lands on the low half
    always_comb begin
        stage1 = STAGE1_LEN'(square[2*`SQ_VALUE_LEN-1:`SQ_VALUE_LEN]) *
                 STAGE1_LEN'(`SQ_FOLD_C) +
                 STAGE1_LEN'(square[`SQ_VALUE_LEN-1:0]);

        // Seven bits left above the low half
        stage2 = STAGE2_LEN'(stage1[`SQ_VALUE_LEN-1:0]) +
                 STAGE2_LEN'(stage1[STAGE1_LEN-1:`SQ_VALUE_LEN]) *
                 STAGE2_LEN'(`SQ_FOLD_C);

        // A set top bit implies a tiny low half, so this cannot overflow
        folded = stage2[`SQ_VALUE_LEN-1:0] +
                 (stage2[`SQ_VALUE_LEN] ? value_t'(`SQ_FOLD_C) : '0);
    end

    // Running value of the squaring chain
    always_ff @(posedge clk) begin
        if (load) begin
            value <= sq_in;
        end else if (fold) begin
            value <= folded;
        end
    end

endmodule

`default_nettype wire

// File: design/sq_final_sub.sv
`timescale 1ns/1ps
`default_nettype none

`include "sq_cfg.svh"

module sq_final_sub
    import sq_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   finish,
    input  wire value_t value,
    output value_t      sq_out,
    output logic        valid
);

    localparam value_t MODULUS =
        value_t'({`SQ_VALUE_LEN{1'b1}}) - value_t'(`SQ_FOLD_C - 1);

    logic [`SQ_VALUE_LEN:0] diff;
    logic                   borrow;
    value_t                 reduced;

    // Value is below 2^64 < 2P, one subtraction is enough
    assign diff   = {1'b0, value} - {1'b0, MODULUS};
    assign borrow = diff[`SQ_VALUE_LEN];

    // Borrow means value already below P
    assign reduced = borrow ? value : diff[`SQ_VALUE_LEN-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            sq_out <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= finish;
            if (finish) begin
                sq_out <= reduced;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/sq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sq_cfg.svh"

module sq_top
    import sq_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   start,
    input  wire value_t sq_in,
    input  wire count_t iterations,
    output logic        busy,
    output logic        valid,
    output value_t      sq_out
);

    logic    load;
    logic    fold;
    logic    finish;
    value_t  value;
    square_t square;

    sq_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .iterations (iterations),
        .load       (load),
        .fold       (fold),
        .finish     (finish),
        .busy       (busy)
    );

    // One cycle square, one cycle fold
    sq_limb_square u_square (
        .clk    (clk),
        .value  (value),
        .square (square)
    );

    sq_fold_reduce u_reduce (
        .clk    (clk),
        .load   (load),
        .fold   (fold),
        .sq_in  (sq_in),
        .square (square),
        .value  (value)
    );

    sq_final_sub u_final (
        .clk    (clk),
        .reset  (reset),
        .finish (finish),
        .value  (value),
        .sq_out (sq_out),
        .valid  (valid)
    );

endmodule

`default_nettype wire

// File: bench/sq_sva.sv
`timescale 1ns/1ps
`default_nettype none

module sq_sva
    import sq_pkg::*;
(
    input wire logic   clk,
    input wire logic   reset,
    input wire logic   busy,
    input wire logic   valid,
    input wire value_t sq_out
);

    // P = 2^64 - 59
    localparam value_t MODULUS = 64'hffff_ffff_ffff_ffc5;

    // Result strobe is a single-cycle pulse
    valid_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        valid |=> !valid
    ) else $error("valid stayed high for two cycles");

    // Result is fully reduced
    result_below_p: assert property (
        @(posedge clk) disable iff (reset)
        valid |-> (sq_out < MODULUS)
    ) else $error("sq_out 0x%016h not below modulus", sq_out);

    // Engine goes idle on the edge that raises valid
    busy_falls_with_valid: assert property (
        @(posedge clk) disable iff (reset)
        $rose(valid) |-> $fell(busy)
    ) else $error("busy did not fall together with valid");

endmodule

bind sq_top sq_sva u_sva (
    .clk    (clk),
    .reset  (reset),
    .busy   (busy),
    .valid  (valid),
    .sq_out (sq_out)
);

`default_nettype wire

// File: bench/sq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sq_tb
    import sq_pkg::*;
();

    localparam value_t MODULUS       = 64'hffff_ffff_ffff_ffc5;
    localparam int     TIMEOUT_EDGES = 100;
    localparam int     NUM_RANDOM    = 10;

    logic   clk;
    logic   reset;
    logic   start;
    value_t sq_in;
    count_t iterations;
    logic   busy;
    logic   valid;
    value_t sq_out;

    // Stimulus table: input, squaring count, start mode, expected result
    value_t tab_in[$];
    count_t tab_iter[$];
    int     tab_mode[$];
    value_t tab_exp[$];

    value_t last_out;
    integer seed;

    sq_top UUT (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .sq_in      (sq_in),
        .iterations (iterations),
        .busy       (busy),
        .valid      (valid),
        .sq_out     (sq_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    function automatic value_t square_mod(input value_t a);
        logic [127:0] wide;
        wide = {64'd0, a} * {64'd0, a};
        return value_t'(wide % {64'd0, MODULUS});
    endfunction

    // Reference model, plain repeated squaring modulo 2^64 - 59
    function automatic value_t expected_result(input value_t x, input count_t n);
        value_t acc;
        acc = x % MODULUS;
        for (int i = 0; i < int'(n); i++) begin
            acc = square_mod(acc);
        end
        return acc;
    endfunction

    task automatic check_value(input string name, input value_t got, input value_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%016h, expected 0x%016h", name, got, exp);
            $display("Test failed");
            $fatal(1, "%s compare error", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "%s compare error", name);
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic add_entry(input value_t in_val, input count_t n, input int mode);
        tab_in.push_back(in_val);
        tab_iter.push_back(n);
        tab_mode.push_back(mode);
        tab_exp.push_back(expected_result(in_val, n));
    endtask

    task automatic build_table();
        value_t r;
        count_t n;
        // Zero iterations, only the final correction
        add_entry(64'd5, 0, 0);
        add_entry(MODULUS - 1, 0, 0);
        add_entry(MODULUS, 0, 0);
        add_entry(MODULUS + 1, 0, 0);
        add_entry(64'hffff_ffff_ffff_fffe, 0, 0);
        add_entry('1, 0, 0);
        add_entry(64'd2, 1, 0);
        add_entry(64'd2, 6, 0);
        add_entry(64'd3, 2, 0);
        add_entry(64'd3, 8, 0);
        add_entry(MODULUS - 1, 1, 0);
        add_entry(MODULUS - 1, 3, 0);
        add_entry('1, 4, 0);
        add_entry(64'h0123_4567_89ab_cdef, 5, 0);
        add_entry(64'd0, 3, 0);
        add_entry(64'd1, 7, 0);
        // Mode 1 holds start high, mode 2 pulses it while busy
        add_entry(64'hdead_beef_0bad_f00d, 3, 1);
        add_entry(64'd7, 0, 1);
        add_entry(64'hcafe_0000_1234_5678, 5, 2);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = {$random(seed), $random(seed)};
            n = count_t'(1 + ($unsigned($random(seed)) % 20));
            add_entry(r, n, 0);
        end
    endtask

    task automatic run_entry(input int idx);
        value_t in_val;
        count_t n;
        int     mode;
        int     lat;
        int     edges;
        logic   seen;
        in_val = tab_in[idx];
        n      = tab_iter[idx];
        mode   = tab_mode[idx];
        lat    = 2 * int'(n) + 1;

        sq_in      = in_val;
        iterations = n;
        start      = 1'b1;
        next_edge();

        // Changed inputs must not reach the run in progress
        sq_in      = in_val ^ 64'h5a5a_a5a5_0ff0_f00f;
        iterations = n + count_t'(3);
        start      = (mode == 1);

        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            next_edge();
            edges++;
            if (edges > TIMEOUT_EDGES) begin
                $display("Timeout: valid did not rise within %0d clock edges", TIMEOUT_EDGES);
                $display("Test failed");
                $fatal(1, "no valid pulse");
            end
            check_bit("valid", valid, edges == lat);
            check_bit("busy", busy, edges < lat);
            if (edges < lat) begin
                check_value("sq_out", sq_out, last_out);
            end
            start = (mode == 1) || ((mode == 2) && edges[0]);
            seen  = valid;
        end
        start = 1'b0;

        check_value("sq_out", sq_out, tab_exp[idx]);
        last_out = tab_exp[idx];

        // One-cycle strobe, result held afterwards
        next_edge();
        check_bit("valid", valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_value("sq_out", sq_out, last_out);
    endtask

    initial begin
        seed       = 32'hdb1a1cde;
        reset      = 1'b1;
        start      = 1'b0;
        sq_in      = '0;
        iterations = '0;
        last_out   = '0;
        build_table();

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        check_bit("valid", valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_value("sq_out", sq_out, '0);
        check_bit("state_idle", UUT.u_ctrl.state == IDLE, 1'b1);

        for (int i = 0; i < tab_in.size(); i++) begin
            run_entry(i);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/sq_pkg.sv
design/sq_ctrl.sv
design/sq_limb_square.sv
design/sq_fold_reduce.sv
design/sq_final_sub.sv
design/sq_top.sv
bench/sq_sva.sv
bench/sq_tb.sv

// File: Bender.yml
package:
  name: sq_engine

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/sq_pkg.sv
      - design/sq_ctrl.sv
      - design/sq_limb_square.sv
      - design/sq_fold_reduce.sv
      - design/sq_final_sub.sv
      - design/sq_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/sq_sva.sv
      - bench/sq_tb.sv
